//--- rtl/conv_pkg.sv
`default_nettype none

package conv_pkg;

    // =====================================================================
    // kernel geometry and widths
    // =====================================================================
    localparam int KX             = 5;
    localparam int KY             = 5;
    localparam int KTAPS          = KX * KY;
    localparam int TAP_BW         = $clog2(KTAPS);
    localparam int W_BW           = 8;
    localparam int IBW            = 20;
    localparam int M_BW           = W_BW + IBW;
    // 5 guard bits cover the 25-term sum
    localparam int AK_BW          = M_BW + 5;
    localparam int KERNEL_LATENCY = 3 + KTAPS;

    localparam int FIFO_DEPTH  = 4;
    localparam int FIFO_PTR_BW = $clog2(FIFO_DEPTH);
    localparam int CNT_BW      = $clog2(FIFO_DEPTH + 1);

    // =====================================================================
    // AXI4-Lite and register map
    // =====================================================================
    localparam int AXIL_AW = 12;
    localparam int AXIL_DW = 32;

    // write space
    localparam logic [AXIL_AW-1:0] ADDR_WEIGHT_BASE = 12'h000;
    localparam logic [AXIL_AW-1:0] ADDR_FMAP_BASE   = 12'h080;
    localparam logic [AXIL_AW-1:0] ADDR_START       = 12'h100;
    // read space
    localparam logic [AXIL_AW-1:0] ADDR_STATUS      = 12'h000;
    localparam logic [AXIL_AW-1:0] ADDR_RESULT      = 12'h004;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef struct packed {
        logic               awvalid;
        logic [AXIL_AW-1:0] awaddr;
        logic               wvalid;
        logic [AXIL_DW-1:0] wdata;
        logic               bready;
    } axil_wr_req_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        logic [1:0] bresp;
    } axil_wr_rsp_t;

    typedef struct packed {
        logic               arvalid;
        logic [AXIL_AW-1:0] araddr;
        logic               rready;
    } axil_rd_req_t;

    typedef struct packed {
        logic               arready;
        logic               rvalid;
        logic [AXIL_DW-1:0] rdata;
        logic [1:0]         rresp;
    } axil_rd_rsp_t;

    // tap index is y*KX+x
    typedef struct packed {
        logic [KTAPS-1:0][W_BW-1:0] weight;
        logic [KTAPS-1:0][IBW-1:0]  fmap;
    } conv_window_t;

    typedef struct packed {
        logic signed [AK_BW-1:0] acc;
    } conv_result_t;

endpackage

`default_nettype wire

//--- rtl/conv_kernel_5x5.sv
`timescale 1ns/1ps
`default_nettype none

module conv_kernel_5x5
    import conv_pkg::*;
(
    input  logic         clk,
    input  logic         reset_n,
    input  logic         i_in_valid,
    input  conv_window_t i_window,
    output logic         o_ot_valid,
    output conv_result_t o_ot_kernel_acc
);

    logic [KERNEL_LATENCY-1:0] r_valid;

    logic signed [M_BW-1:0]  mul [KTAPS];
    // stage, tap
    logic signed [M_BW-1:0]  r_mul [KTAPS][KTAPS];
    logic signed [AK_BW-1:0] acc_kernel [KTAPS];
    conv_result_t            r_acc_kernel;

    // =====================================================================
    // valid shift line, one bit per pipeline stage
    // =====================================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_valid <= '0;
        end else begin
            r_valid <= {r_valid[KERNEL_LATENCY-2:0], i_in_valid};
        end
    end

    // =====================================================================
    // products, all 25 taps in one stage
    // =====================================================================
    always_ff @(posedge clk) begin
        if (i_in_valid) begin
            for (int k = 0; k < KTAPS; k++) begin
                mul[k] <= $signed(i_window.weight[k]) * $signed(i_window.fmap[k]);
            end
        end
    end

    // product set walks down the line, stage s feeds tap s
    always_ff @(posedge clk) begin
        if (r_valid[0]) begin
            r_mul[0] <= mul;
        end
        for (int s = 1; s < KTAPS; s++) begin
            if (r_valid[s]) begin
                r_mul[s] <= r_mul[s-1];
            end
        end
    end

    // =====================================================================
    // accumulate chain
    // =====================================================================
    always_ff @(posedge clk) begin
        if (r_valid[1]) begin
            acc_kernel[0] <= AK_BW'(r_mul[0][0]);
        end
        for (int k = 1; k < KTAPS; k++) begin
            if (r_valid[k+1]) begin
                acc_kernel[k] <= acc_kernel[k-1] + AK_BW'(r_mul[k][k]);
            end
        end
    end

    // output register, lands together with the last valid bit
    always_ff @(posedge clk) begin
        if (r_valid[KTAPS+1]) begin
            r_acc_kernel.acc <= acc_kernel[KTAPS-1];
        end
    end

    assign o_ot_valid      = r_valid[KERNEL_LATENCY-1];
    assign o_ot_kernel_acc = r_acc_kernel;

endmodule

`default_nettype wire

//--- rtl/conv_window_loader.sv
`timescale 1ns/1ps
`default_nettype none

module conv_window_loader
    import conv_pkg::*;
(
    input  logic         clk,
    input  logic         reset_n,
    input  axil_wr_req_t i_wr_req,
    output axil_wr_rsp_t o_wr_rsp,
    input  logic         i_can_reserve,
    output logic         o_launch,
    output conv_window_t o_window
);

    logic [AXIL_AW-1:0] w_off;
    logic [AXIL_AW-1:0] f_off;
    logic [TAP_BW-1:0]  w_idx;
    logic [TAP_BW-1:0]  f_idx;
    logic               hit_weight;
    logic               hit_fmap;
    logic               hit_start;
    logic               wr_accept;
    logic               bvalid;
    logic [1:0]         bresp;
    conv_window_t       r_window;

    // =====================================================================
    // address decode
    // =====================================================================
    always_comb begin
        w_off      = i_wr_req.awaddr - ADDR_WEIGHT_BASE;
        f_off      = i_wr_req.awaddr - ADDR_FMAP_BASE;
        w_idx      = w_off[2 +: TAP_BW];
        f_idx      = f_off[2 +: TAP_BW];
        hit_weight = (i_wr_req.awaddr >= ADDR_WEIGHT_BASE) && (w_off < AXIL_AW'(KTAPS * 4));
        hit_fmap   = (i_wr_req.awaddr >= ADDR_FMAP_BASE) && (f_off < AXIL_AW'(KTAPS * 4));
        hit_start  = (i_wr_req.awaddr == ADDR_START);
    end

    // AW and W taken together, START waits for a free FIFO slot
    assign wr_accept = i_wr_req.awvalid && i_wr_req.wvalid && !bvalid
                       && (!hit_start || i_can_reserve);

    // staging registers keep the low bits of wdata
    always_ff @(posedge clk) begin
        if (wr_accept && hit_weight) begin
            r_window.weight[w_idx] <= i_wr_req.wdata[W_BW-1:0];
        end
        if (wr_accept && hit_fmap) begin
            r_window.fmap[f_idx] <= i_wr_req.wdata[IBW-1:0];
        end
    end

    // =====================================================================
    // launch pulse and B channel
    // =====================================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            bvalid   <= 1'b0;
            o_launch <= 1'b0;
        end else begin
            o_launch <= wr_accept && hit_start;
            if (wr_accept) begin
                bvalid <= 1'b1;
            end else if (i_wr_req.bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // unmapped address, no side effect
    always_ff @(posedge clk) begin
        if (wr_accept) begin
            bresp <= (hit_weight || hit_fmap || hit_start) ? RESP_OKAY : RESP_SLVERR;
        end
    end

    assign o_wr_rsp.awready = wr_accept;
    assign o_wr_rsp.wready  = wr_accept;
    assign o_wr_rsp.bvalid  = bvalid;
    assign o_wr_rsp.bresp   = bresp;
    assign o_window         = r_window;

endmodule

`default_nettype wire

//--- rtl/result_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module result_fifo
    import conv_pkg::*;
#(
    parameter type T = conv_result_t
) (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              i_reserve,
    output logic              o_can_reserve,
    input  logic              i_push,
    input  T                  i_push_data,
    input  logic              i_pop,
    output T                  o_head,
    output logic [CNT_BW-1:0] o_count
);

    T                       mem [FIFO_DEPTH];
    logic [FIFO_PTR_BW-1:0] wr_ptr;
    logic [FIFO_PTR_BW-1:0] rd_ptr;
    logic [CNT_BW-1:0]      stored_cnt;
    logic [CNT_BW-1:0]      reserved_cnt;
    logic [CNT_BW:0]        used_cnt;
    logic                   do_pop;

    assign do_pop   = i_pop && (stored_cnt != '0);
    assign used_cnt = stored_cnt + reserved_cnt;

    // results come back in launch order, so the oldest reservation sits at wr_ptr
    always_ff @(posedge clk) begin
        if (i_push) begin
            mem[wr_ptr] <= i_push_data;
        end
    end

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            stored_cnt   <= '0;
            reserved_cnt <= '0;
        end else begin
            if (i_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            stored_cnt   <= stored_cnt + CNT_BW'(i_push) - CNT_BW'(do_pop);
            reserved_cnt <= reserved_cnt + CNT_BW'(i_reserve) - CNT_BW'(i_push);
        end
    end

    assign o_can_reserve = (used_cnt < FIFO_DEPTH);
    assign o_head        = mem[rd_ptr];
    assign o_count       = stored_cnt;

endmodule

`default_nettype wire

//--- rtl/result_reader.sv
`timescale 1ns/1ps
`default_nettype none

module result_reader
    import conv_pkg::*;
(
    input  logic              clk,
    input  logic              reset_n,
    input  axil_rd_req_t      i_rd_req,
    output axil_rd_rsp_t      o_rd_rsp,
    input  conv_result_t      i_head,
    input  logic [CNT_BW-1:0] i_count,
    output logic              o_pop
);

    logic               rd_accept;
    logic               is_status;
    logic               is_result;
    logic               rvalid;
    logic [AXIL_DW-1:0] rdata;
    logic [1:0]         rresp;

    // one read outstanding at a time
    assign rd_accept = i_rd_req.arvalid && !rvalid;
    assign is_status = (i_rd_req.araddr == ADDR_STATUS);
    assign is_result = (i_rd_req.araddr == ADDR_RESULT);
    assign o_pop     = rd_accept && is_result && (i_count != '0);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rvalid <= 1'b0;
        end else if (rd_accept) begin
            rvalid <= 1'b1;
        end else if (i_rd_req.rready) begin
            rvalid <= 1'b0;
        end
    end

    // signed sum always fits in 32 bits, the cast keeps the sign
    always_ff @(posedge clk) begin
        if (rd_accept) begin
            if (is_status) begin
                rdata <= AXIL_DW'(i_count);
                rresp <= RESP_OKAY;
            end else if (o_pop) begin
                rdata <= AXIL_DW'(i_head.acc);
                rresp <= RESP_OKAY;
            end else begin
                // empty FIFO or unmapped address
                rdata <= '0;
                rresp <= RESP_SLVERR;
            end
        end
    end

    assign o_rd_rsp.arready = !rvalid;
    assign o_rd_rsp.rvalid  = rvalid;
    assign o_rd_rsp.rdata   = rdata;
    assign o_rd_rsp.rresp   = rresp;

endmodule

`default_nettype wire

//--- rtl/conv_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module conv_core_top
    import conv_pkg::*;
(
    input  logic         clk,
    input  logic         reset_n,
    input  axil_wr_req_t i_wr_req,
    output axil_wr_rsp_t o_wr_rsp,
    input  axil_rd_req_t i_rd_req,
    output axil_rd_rsp_t o_rd_rsp
);

    logic              launch;
    logic              can_reserve;
    conv_window_t      window;
    logic              ot_valid;
    conv_result_t      ot_acc;
    logic              pop;
    conv_result_t      head;
    logic [CNT_BW-1:0] count;

    // =====================================================================
    // producer, kernel, buffer, consumer
    // =====================================================================
    conv_window_loader u_loader (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_wr_req      (i_wr_req),
        .o_wr_rsp      (o_wr_rsp),
        .i_can_reserve (can_reserve),
        .o_launch      (launch),
        .o_window      (window)
    );

    conv_kernel_5x5 u_kernel (
        .clk             (clk),
        .reset_n         (reset_n),
        .i_in_valid      (launch),
        .i_window        (window),
        .o_ot_valid      (ot_valid),
        .o_ot_kernel_acc (ot_acc)
    );

    // launch takes its slot in the same cycle it enters the kernel
    result_fifo #(
        .T (conv_result_t)
    ) u_fifo (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_reserve     (launch),
        .o_can_reserve (can_reserve),
        .i_push        (ot_valid),
        .i_push_data   (ot_acc),
        .i_pop         (pop),
        .o_head        (head),
        .o_count       (count)
    );

    result_reader u_reader (
        .clk      (clk),
        .reset_n  (reset_n),
        .i_rd_req (i_rd_req),
        .o_rd_rsp (o_rd_rsp),
        .i_head   (head),
        .i_count  (count),
        .o_pop    (pop)
    );

endmodule

`default_nettype wire

//--- verif/conv_core_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module conv_core_asserts
    import conv_pkg::*;
(
    input logic            clk,
    input logic            reset_n,
    input axil_wr_req_t    i_wr_req,
    input axil_wr_rsp_t    i_wr_rsp,
    input axil_rd_req_t    i_rd_req,
    input axil_rd_rsp_t    i_rd_rsp,
    input logic            i_launch,
    input logic            i_ot_valid,
    input logic [CNT_BW:0] i_used_cnt
);

    // kernel output trails its input by the full pipeline depth
    a_kernel_latency: assert property (@(posedge clk) disable iff (!reset_n)
        i_ot_valid == $past(i_launch, KERNEL_LATENCY))
        else $error("kernel output valid out of step with launch");

    a_fifo_bound: assert property (@(posedge clk) disable iff (!reset_n)
        i_used_cnt <= FIFO_DEPTH)
        else $error("FIFO stored plus reserved entries exceed depth");

    // =====================================================================
    // response channels hold until accepted
    // =====================================================================
    a_b_stable: assert property (@(posedge clk) disable iff (!reset_n)
        i_wr_rsp.bvalid && !i_wr_req.bready |=> i_wr_rsp.bvalid && $stable(i_wr_rsp.bresp))
        else $error("B response dropped or changed before BREADY");

    a_r_stable: assert property (@(posedge clk) disable iff (!reset_n)
        i_rd_rsp.rvalid && !i_rd_req.rready |=> i_rd_rsp.rvalid
            && $stable(i_rd_rsp.rdata) && $stable(i_rd_rsp.rresp))
        else $error("R response dropped or changed before RREADY");

endmodule

bind conv_core_top conv_core_asserts u_asserts (
    .clk        (clk),
    .reset_n    (reset_n),
    .i_wr_req   (i_wr_req),
    .i_wr_rsp   (o_wr_rsp),
    .i_rd_req   (i_rd_req),
    .i_rd_rsp   (o_rd_rsp),
    .i_launch   (launch),
    .i_ot_valid (ot_valid),
    .i_used_cnt (u_fifo.used_cnt)
);

`default_nettype wire

//--- verif/conv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module conv_core_tb
    import conv_pkg::*;
();

    localparam int N_WINDOWS       = 12;
    localparam int WATCHDOG_CYCLES = 200 * N_WINDOWS + 2000;
    // enough to load one more window behind a full FIFO
    localparam int STALL_CYCLES    = 200;

    logic               clk;
    logic               reset_n;
    axil_wr_req_t       wr_req;
    axil_wr_rsp_t       wr_rsp;
    axil_rd_req_t       rd_req;
    axil_rd_rsp_t       rd_rsp;
    int                 w [KTAPS];
    int                 f [KTAPS];
    logic [31:0]        rng_state = 32'h3b61_aa38;
    logic [31:0]        exp_q [$];
    logic [AXIL_AW-1:0] rd_addr_q;
    int                 errors = 0;
    int                 compared = 0;
    int                 starts_done = 0;
    string              test_name = "reset";

    conv_core_top dut0 (
        .clk      (clk),
        .reset_n  (reset_n),
        .i_wr_req (wr_req),
        .o_wr_rsp (wr_rsp),
        .i_rd_req (rd_req),
        .o_rd_rsp (rd_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // =====================================================================
    // reference model and random source
    // =====================================================================
    function automatic logic [31:0] expected_acc(input int wt [KTAPS], input int fm [KTAPS]);
        longint sum;
        sum = 0;
        for (int k = 0; k < KTAPS; k++) begin
            sum += longint'(wt[k]) * longint'(fm[k]);
        end
        return sum[31:0];
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic random_window();
        for (int k = 0; k < KTAPS; k++) begin
            rng_state = xorshift32(rng_state);
            w[k] = int'($signed(rng_state[W_BW-1:0]));
            rng_state = xorshift32(rng_state);
            f[k] = int'($signed(rng_state[IBW-1:0]));
        end
    endtask

    task automatic expect_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s %s: expected 0x%08h, actual 0x%08h", test_name, what, exp, act);
        end
    endtask

    // =====================================================================
    // bus tasks start right after a rising edge
    // =====================================================================
    // BREADY and RREADY come one cycle late so the responses must hold
    task automatic axil_write(input logic [AXIL_AW-1:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        wr_req.awvalid <= 1'b1;
        wr_req.awaddr  <= addr;
        wr_req.wvalid  <= 1'b1;
        wr_req.wdata   <= data;
        wr_req.bready  <= 1'b0;
        do @(posedge clk); while (!wr_rsp.awready);
        if (!wr_rsp.wready) begin
            errors++;
            $display("%s: WREADY was low in the cycle the address was accepted", test_name);
        end
        wr_req.awvalid <= 1'b0;
        wr_req.wvalid  <= 1'b0;
        do @(posedge clk); while (!wr_rsp.bvalid);
        resp = wr_rsp.bresp;
        wr_req.bready <= 1'b1;
        @(posedge clk);
        wr_req.bready <= 1'b0;
    endtask

    task automatic axil_read(input logic [AXIL_AW-1:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        rd_req.arvalid <= 1'b1;
        rd_req.araddr  <= addr;
        rd_req.rready  <= 1'b0;
        do @(posedge clk); while (!rd_rsp.arready);
        rd_req.arvalid <= 1'b0;
        do @(posedge clk); while (!rd_rsp.rvalid);
        data = rd_rsp.rdata;
        resp = rd_rsp.rresp;
        rd_req.rready <= 1'b1;
        @(posedge clk);
        rd_req.rready <= 1'b0;
    endtask

    task automatic load_window();
        logic [1:0] resp;
        for (int k = 0; k < KTAPS; k++) begin
            axil_write(ADDR_WEIGHT_BASE + AXIL_AW'(4 * k), 32'(w[k]), resp);
            expect_eq("weight write response", 32'(RESP_OKAY), 32'(resp));
            axil_write(ADDR_FMAP_BASE + AXIL_AW'(4 * k), 32'(f[k]), resp);
            expect_eq("sample write response", 32'(RESP_OKAY), 32'(resp));
        end
    endtask

    // expected value queued once START is answered
    task automatic start_window();
        logic [1:0] resp;
        axil_write(ADDR_START, 32'h1, resp);
        expect_eq("START response", 32'(RESP_OKAY), 32'(resp));
        exp_q.push_back(expected_acc(w, f));
        starts_done++;
    endtask

    task automatic read_result();
        logic [31:0] data;
        logic [1:0]  resp;
        data = '0;
        while (data == 0) begin
            axil_read(ADDR_STATUS, data, resp);
            if (data > FIFO_DEPTH) begin
                errors++;
                $display("[FAIL] %s STATUS: expected at most %0d, actual %0d",
                         test_name, FIFO_DEPTH, data);
            end
        end
        axil_read(ADDR_RESULT, data, resp);
        expect_eq("RESULT response", 32'(RESP_OKAY), 32'(resp));
    endtask

    // =====================================================================
    // every good RESULT read checked against the queue head
    // =====================================================================
    always @(posedge clk) begin : compare_results
        logic [31:0] want;
        if (rd_req.arvalid && rd_rsp.arready) begin
            rd_addr_q <= rd_req.araddr;
        end
        if (rd_rsp.rvalid && rd_req.rready && rd_addr_q == ADDR_RESULT
            && rd_rsp.rresp == RESP_OKAY) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("%s: a result was read with no window outstanding", test_name);
            end else begin
                want = exp_q.pop_front();
                compared++;
                if (rd_rsp.rdata !== want) begin
                    errors++;
                    $display("[FAIL] %s result: expected %0d, actual %0d",
                             test_name, $signed(want), $signed(rd_rsp.rdata));
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run stalled", WATCHDOG_CYCLES);
        $display("Test failures found");
        $finish;
    end

    // =====================================================================
    // test sequence
    // =====================================================================
    initial begin
        logic [31:0] data;
        logic [1:0]  resp;
        wr_req  = '0;
        rd_req  = '0;
        reset_n = 1'b0;
        repeat (5) @(posedge clk);
        reset_n <= 1'b1;
        @(posedge clk);

        test_name = "single_window";
        for (int k = 0; k < KTAPS; k++) begin
            w[k] = k - 12;
            f[k] = 3 * k + 1;
        end
        load_window();
        start_window();
        read_result();

        test_name = "pipelined";
        for (int n = 0; n < 3; n++) begin
            random_window();
            load_window();
            start_window();
        end
        for (int n = 0; n < 3; n++) begin
            read_result();
        end

        // reader runs alongside the two STARTs past FIFO depth
        test_name = "backpressure";
        starts_done = 0;
        fork
            begin
                for (int n = 0; n < FIFO_DEPTH + 2; n++) begin
                    random_window();
                    load_window();
                    start_window();
                end
            end
            begin
                while (starts_done < FIFO_DEPTH) @(posedge clk);
                repeat (STALL_CYCLES) @(posedge clk);
                expect_eq("completed STARTs", 32'(FIFO_DEPTH), 32'(starts_done));
                axil_read(ADDR_STATUS, data, resp);
                expect_eq("STATUS when full", 32'(FIFO_DEPTH), data);
                for (int n = 0; n < FIFO_DEPTH + 2; n++) begin
                    read_result();
                end
            end
        join

        test_name = "extreme";
        for (int k = 0; k < KTAPS; k++) begin
            w[k] = -(1 << (W_BW - 1));
            f[k] = -(1 << (IBW - 1));
        end
        load_window();
        start_window();
        read_result();

        test_name = "error_responses";
        axil_read(ADDR_RESULT, data, resp);
        expect_eq("empty RESULT data", 32'h0, data);
        expect_eq("empty RESULT response", 32'(RESP_SLVERR), 32'(resp));
        random_window();
        load_window();
        // unmapped, its low offset bits point at tap 1 of both blocks
        axil_write(12'h104, 32'hdead_beef, resp);
        expect_eq("unmapped write response", 32'(RESP_SLVERR), 32'(resp));
        start_window();
        read_result();

        repeat (4) @(posedge clk);
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d launched windows never returned a result", exp_q.size());
        end
        $display("results compared: %0d, errors: %0d", compared, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
rtl/conv_pkg.sv
rtl/conv_kernel_5x5.sv
rtl/conv_window_loader.sv
rtl/result_fifo.sv
rtl/result_reader.sv
rtl/conv_core_top.sv
verif/conv_core_asserts.sv
verif/conv_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the convolution core testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module conv_core_tb \
    -f build.f > build.log 2>&1 \
    && ./obj_dir/Vconv_core_tb > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation aborted"; exit 1; }

cat sim.log
grep -q "Test failures found" sim.log && exit 1 || exit 0
